// File: rtl/glay_defs.svh
`ifndef GLAY_DEFS_SVH
`define GLAY_DEFS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Byte address into memory
`define GLAY_ADDR_BITS 32

// One configuration word
`define GLAY_DATA_BITS 32

// Word count and delivered index
`define GLAY_COUNT_BITS 16

// Address step between consecutive words
`define GLAY_WORD_BYTES 4

// ------------------------------
// Flow control
// ------------------------------

// Memory port credits held out of reset
`define GLAY_MEM_CREDITS 4

// Queue entries, also the outstanding read limit
`define GLAY_FIFO_DEPTH 8

`endif

// File: rtl/glay_mem_pkg.sv
`include "glay_defs.svh"

package glay_mem_pkg;

  // ------------------------------
  // Memory transactions
  // ------------------------------

  // Read request toward memory
  // Only reads exist, so the address is the whole request
  typedef struct packed {
    logic [`GLAY_ADDR_BITS-1:0] addr;
  } mem_request_t;

  // Read data coming back
  // Responses return in request order, so no tag is carried
  typedef struct packed {
    logic [`GLAY_DATA_BITS-1:0] data;
  } mem_response_t;

endpackage : glay_mem_pkg

// File: rtl/glay_control_pkg.sv
`include "glay_defs.svh"

package glay_control_pkg;

  // ------------------------------
  // Host side control
  // ------------------------------

  // Setup descriptor sampled at start
  typedef struct packed {
    logic [`GLAY_ADDR_BITS-1:0]  base_addr;
    logic [`GLAY_COUNT_BITS-1:0] num_words;
  } glay_descriptor_t;

  // Kernel handshake states
  // Done holds until the host acknowledges with ap_continue
  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_busy,
    ctrl_done
  } control_state_t;

endpackage : glay_control_pkg

// File: rtl/glay_fifo_if.sv
`timescale 1ns/1ps

// Push/pop queue link between a producer, a queue and a consumer
interface glay_fifo_if #(
  parameter type payload_t = logic
);

  // Write side
  logic     push;
  payload_t push_data;
  logic     full;

  // Read side
  logic     pop;
  payload_t pop_data;
  logic     empty;

  // Writer raises push only while full is low
  modport producer (
    output push,
    output push_data,
    input  full
  );

  // Reader sees the head entry and raises pop only while empty is low
  modport consumer (
    output pop,
    input  pop_data,
    input  empty
  );

  // Storage side owns the flags and the head data
  modport queue (
    input  push,
    input  push_data,
    input  pop,
    output full,
    output empty,
    output pop_data
  );

endinterface : glay_fifo_if

// File: rtl/glay_sync_fifo.sv
`timescale 1ns/1ps
`include "glay_defs.svh"

module glay_sync_fifo #(
  parameter type payload_t = logic
) (
  input logic        ap_clk,
  input logic        control_areset,
  glay_fifo_if.queue fifo
);

  localparam int depth    = `GLAY_FIFO_DEPTH;
  localparam int ptr_bits = $clog2(depth);
  localparam int cnt_bits = $clog2(depth + 1);

  // ------------------------------
  // Storage and pointers
  // ------------------------------
  payload_t            storage [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                wr_en;
  logic                rd_en;

  // Flags straight from the occupancy count
  assign fifo.full  = (count == cnt_bits'(depth));
  assign fifo.empty = (count == '0);

  // Guarded strobes, simultaneous push and pop allowed
  assign wr_en = fifo.push && !fifo.full;
  assign rd_en = fifo.pop && !fifo.empty;

  // Head entry always visible to the reader
  assign fifo.pop_data = storage[rd_ptr];

  // Payload write
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      storage[wr_ptr] <= fifo.push_data;
    end
  end

  // Pointers wrap at depth
  // Occupancy moves only when exactly one side is active
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : glay_sync_fifo

// File: rtl/glay_kernel_control.sv
`timescale 1ns/1ps
`include "glay_defs.svh"

module glay_kernel_control
  import glay_control_pkg::*;
(
  input  logic                        ap_clk,
  input  logic                        control_areset,
  input  logic                        ap_start,
  input  logic                        ap_continue,
  input  logic [`GLAY_ADDR_BITS-1:0]  desc_base_addr,
  input  logic [`GLAY_COUNT_BITS-1:0] desc_num_words,
  input  logic                        setup_done,
  output logic                        ap_ready,
  output logic                        ap_done,
  output logic                        ap_idle,
  output logic                        start,
  output glay_descriptor_t            descriptor
);

  // ------------------------------
  // Handshake state
  // ------------------------------
  control_state_t state;
  logic           accept;

  // Start only taken while idle
  assign accept = ap_start && (state == ctrl_idle);

  // Host visible status decoded from the state
  assign ap_idle = (state == ctrl_idle);
  assign ap_done = (state == ctrl_done);

  // Setup kick coincides with ap_ready
  assign start = ap_ready;

  // ap_ready is a one cycle echo of the accepted start
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      ap_ready <= 1'b0;
    end else begin
      ap_ready <= accept;
    end
  end

  // Idle to busy on start
  // Busy to done when setup reports the last word taken
  // Done back to idle on host acknowledge
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state <= ctrl_idle;
    end else begin
      case (state)
        ctrl_idle: begin
          if (accept) begin
            state <= ctrl_busy;
          end
        end
        ctrl_busy: begin
          if (setup_done) begin
            state <= ctrl_done;
          end
        end
        ctrl_done: begin
          if (ap_continue) begin
            state <= ctrl_idle;
          end
        end
        default: begin
          state <= ctrl_idle;
        end
      endcase
    end
  end

  // ------------------------------
  // Descriptor capture
  // ------------------------------

  // Held stable for the whole run
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      descriptor.base_addr <= desc_base_addr;
      descriptor.num_words <= desc_num_words;
    end
  end

endmodule : glay_kernel_control

// File: rtl/glay_kernel_setup.sv
`timescale 1ns/1ps
`include "glay_defs.svh"

module glay_kernel_setup
  import glay_mem_pkg::*, glay_control_pkg::*;
(
  input  logic                        ap_clk,
  input  logic                        control_areset,
  input  logic                        start,
  input  glay_descriptor_t            descriptor,
  input  logic                        cfg_ready,
  output logic                        setup_done,
  output logic                        cfg_valid,
  output logic [`GLAY_DATA_BITS-1:0]  cfg_data,
  output logic [`GLAY_COUNT_BITS-1:0] cfg_index,
  glay_fifo_if.producer               req_q,
  glay_fifo_if.consumer               resp_q
);

  // ------------------------------
  // Request side state
  // ------------------------------
  logic [`GLAY_ADDR_BITS-1:0]  req_addr;
  logic [`GLAY_COUNT_BITS-1:0] req_remaining;
  logic                        req_push;
  mem_request_t                req_entry;

  // ------------------------------
  // Delivery side state
  // ------------------------------
  logic [`GLAY_COUNT_BITS-1:0] delivered;
  logic                        active;
  logic                        cfg_accept;
  mem_response_t               resp_head;

  // One request per cycle while words remain and the queue has room
  assign req_push        = (req_remaining != '0) && !req_q.full;
  assign req_entry.addr  = req_addr;
  assign req_q.push      = req_push;
  assign req_q.push_data = req_entry;

  // Queue head drives the config stream directly
  assign resp_head  = resp_q.pop_data;
  assign cfg_valid  = !resp_q.empty;
  assign cfg_data   = resp_head.data;
  assign cfg_accept = cfg_valid && cfg_ready;
  assign resp_q.pop = cfg_accept;

  // Index of the word currently offered
  assign cfg_index = delivered;

  // All words accepted
  // Zero count lands here on the cycle after start
  assign setup_done = active && (delivered == descriptor.num_words);

  // Next word address
  // Loaded from the descriptor at start
  always_ff @(posedge ap_clk) begin
    if (start) begin
      req_addr <= descriptor.base_addr;
    end else if (req_push) begin
      req_addr <= req_addr + `GLAY_ADDR_BITS'(`GLAY_WORD_BYTES);
    end
  end

  // Run bookkeeping
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      req_remaining <= '0;
      delivered     <= '0;
      active        <= 1'b0;
    end else if (start) begin
      req_remaining <= descriptor.num_words;
      delivered     <= '0;
      active        <= 1'b1;
    end else begin
      if (req_push) begin
        req_remaining <= req_remaining - 1'b1;
      end
      if (cfg_accept) begin
        delivered <= delivered + 1'b1;
      end
      // Single cycle done pulse
      if (setup_done) begin
        active <= 1'b0;
      end
    end
  end

endmodule : glay_kernel_setup

// File: rtl/glay_request_generator.sv
`timescale 1ns/1ps
`include "glay_defs.svh"

module glay_request_generator
  import glay_mem_pkg::*;
(
  input  logic                       ap_clk,
  input  logic                       control_areset,
  input  logic                       mem_req_credit,
  input  logic                       mem_resp_valid,
  input  logic [`GLAY_DATA_BITS-1:0] mem_resp_data,
  input  logic                       resp_pop,
  output logic                       mem_req_valid,
  output logic [`GLAY_ADDR_BITS-1:0] mem_req_addr,
  glay_fifo_if.consumer              req_q,
  glay_fifo_if.producer              resp_q
);

  localparam int credit_bits = $clog2(`GLAY_MEM_CREDITS + 1);
  localparam int out_bits    = $clog2(`GLAY_FIFO_DEPTH + 1);

  // ------------------------------
  // Accounting
  // ------------------------------
  logic [credit_bits-1:0] credits;
  logic [out_bits-1:0]    outstanding;
  logic                   issue;
  mem_request_t           req_head;
  mem_response_t          resp_entry;

  assign req_head = req_q.pop_data;

  // Need a request, a credit and room in the response queue
  assign issue = !req_q.empty && (credits != '0) &&
                 (outstanding < out_bits'(`GLAY_FIFO_DEPTH));

  assign req_q.pop = issue;

  // Credit spent at issue, so the count is already low while valid is up
  // Outstanding counts issued reads not yet popped from resp_q
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      credits     <= credit_bits'(`GLAY_MEM_CREDITS);
      outstanding <= '0;
    end else begin
      credits     <= credits - credit_bits'(issue) + credit_bits'(mem_req_credit);
      outstanding <= outstanding + out_bits'(issue) - out_bits'(resp_pop);
    end
  end

  // ------------------------------
  // Memory port registers
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      mem_req_valid <= 1'b0;
    end else begin
      mem_req_valid <= issue;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (issue) begin
      mem_req_addr <= req_head.addr;
    end
  end

  // Responses go straight in; the outstanding limit keeps resp_q from overflowing
  assign resp_entry.data  = mem_resp_data;
  assign resp_q.push      = mem_resp_valid;
  assign resp_q.push_data = resp_entry;

endmodule : glay_request_generator

// File: rtl/glay_compute_unit.sv
`timescale 1ns/1ps
`include "glay_defs.svh"

module glay_compute_unit
  import glay_mem_pkg::*, glay_control_pkg::*;
(
  input  logic                        ap_clk,
  input  logic                        control_areset,
  // Host handshake
  input  logic                        ap_start,
  input  logic                        ap_continue,
  output logic                        ap_ready,
  output logic                        ap_done,
  output logic                        ap_idle,
  input  logic [`GLAY_ADDR_BITS-1:0]  desc_base_addr,
  input  logic [`GLAY_COUNT_BITS-1:0] desc_num_words,
  // Memory port
  output logic                        mem_req_valid,
  output logic [`GLAY_ADDR_BITS-1:0]  mem_req_addr,
  input  logic                        mem_req_credit,
  input  logic                        mem_resp_valid,
  input  logic [`GLAY_DATA_BITS-1:0]  mem_resp_data,
  // Configuration stream
  output logic                        cfg_valid,
  output logic [`GLAY_DATA_BITS-1:0]  cfg_data,
  output logic [`GLAY_COUNT_BITS-1:0] cfg_index,
  input  logic                        cfg_ready
);

  // ------------------------------
  // Internal links
  // ------------------------------
  glay_descriptor_t descriptor;
  logic             start;
  logic             setup_done;

  // Setup to generator
  glay_fifo_if #(.payload_t(mem_request_t))  req_q ();
  // Generator to setup
  glay_fifo_if #(.payload_t(mem_response_t)) resp_q ();

  // ------------------------------
  // Control
  // ------------------------------
  glay_kernel_control i_glay_kernel_control (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .ap_start      (ap_start),
    .ap_continue   (ap_continue),
    .desc_base_addr(desc_base_addr),
    .desc_num_words(desc_num_words),
    .setup_done    (setup_done),
    .ap_ready      (ap_ready),
    .ap_done       (ap_done),
    .ap_idle       (ap_idle),
    .start         (start),
    .descriptor    (descriptor)
  );

  // ------------------------------
  // Setup engine
  // ------------------------------
  glay_kernel_setup i_glay_kernel_setup (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .start         (start),
    .descriptor    (descriptor),
    .cfg_ready     (cfg_ready),
    .setup_done    (setup_done),
    .cfg_valid     (cfg_valid),
    .cfg_data      (cfg_data),
    .cfg_index     (cfg_index),
    .req_q         (req_q),
    .resp_q        (resp_q)
  );

  // ------------------------------
  // Queues and memory port
  // ------------------------------
  glay_sync_fifo #(.payload_t(mem_request_t)) i_req_fifo (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .fifo          (req_q)
  );

  glay_sync_fifo #(.payload_t(mem_response_t)) i_resp_fifo (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .fifo          (resp_q)
  );

  // Pop of resp_q fed back for outstanding accounting
  glay_request_generator i_glay_request_generator (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .mem_req_credit(mem_req_credit),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp_data (mem_resp_data),
    .resp_pop      (resp_q.pop),
    .mem_req_valid (mem_req_valid),
    .mem_req_addr  (mem_req_addr),
    .req_q         (req_q),
    .resp_q        (resp_q)
  );

endmodule : glay_compute_unit

// File: verification/glay_compute_unit_tb.sv
`timescale 1ns/1ps
`include "glay_defs.svh"

module glay_compute_unit_tb;

  localparam int num_runs    = 12;
  localparam int word_cycles = 64;
  localparam int run_cycles  = 64;
  localparam logic [31:0] lfsr_taps = 32'hB4BC_D35C;

  // ------------------------------
  // DUT connections
  // ------------------------------
  logic                        ap_clk;
  logic                        control_areset;
  logic                        ap_start;
  logic                        ap_continue;
  logic                        ap_ready;
  logic                        ap_done;
  logic                        ap_idle;
  logic [`GLAY_ADDR_BITS-1:0]  desc_base_addr;
  logic [`GLAY_COUNT_BITS-1:0] desc_num_words;
  logic                        mem_req_valid;
  logic [`GLAY_ADDR_BITS-1:0]  mem_req_addr;
  logic                        mem_req_credit;
  logic                        mem_resp_valid;
  logic [`GLAY_DATA_BITS-1:0]  mem_resp_data;
  logic                        cfg_valid;
  logic [`GLAY_DATA_BITS-1:0]  cfg_data;
  logic [`GLAY_COUNT_BITS-1:0] cfg_index;
  logic                        cfg_ready;

  // ------------------------------
  // Model state
  // ------------------------------
  logic [31:0]                lfsr;
  logic [`GLAY_DATA_BITS-1:0] mem_data [bit [`GLAY_ADDR_BITS-1:0]];
  logic [`GLAY_ADDR_BITS-1:0] pending [$];
  logic [`GLAY_ADDR_BITS-1:0] run_base [num_runs];
  int                         run_count [num_runs];
  int                         run_wait [num_runs];
  logic [`GLAY_ADDR_BITS-1:0] cur_base;
  logic [`GLAY_ADDR_BITS-1:0] resp_addr;
  logic [`GLAY_ADDR_BITS-1:0] exp_addr;
  int                         cur_count;
  int                         req_count;
  int                         acc_count;
  int                         credits_held;
  int                         credits_owed;
  int                         outstanding;
  int                         errors;
  int                         tests_failed;
  int                         limit_cycles;
  logic                       pop_seen;
  logic                       stall;
  logic                       in_reset_q;

  glay_compute_unit i_glay_compute_unit (.*);

  // Free running clock of 4 ns period
  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Failure: %s", what);
      errors++;
    end
  endtask

  task automatic close_test(input string name, input int err_start);
    if (errors != err_start) begin
      tests_failed++;
    end
    $display("%s: %0d errors", name, errors - err_start);
  endtask

  // Model starts once the DUT has seen reset low at a rising edge
  always @(posedge ap_clk) begin
    in_reset_q <= control_areset;
  end

  // ------------------------------
  // Memory and stream model
  // ------------------------------
  always @(negedge ap_clk) begin
    if (in_reset_q === 1'b0) begin
      // Request issued at the last rising edge
      if (mem_req_valid) begin
        check_true(credits_held > 0, "request issued with no credit held");
        check_true(req_count < cur_count, "more requests than the word count");
        check_value("mem_req_addr", mem_req_addr, cur_base + req_count * `GLAY_WORD_BYTES);
        pending.push_back(mem_req_addr);
        credits_held--;
        credits_owed++;
        outstanding++;
        req_count++;
      end
      // Credit pulse and pop both landed at that same edge
      if (mem_req_credit) begin
        credits_held++;
      end
      if (pop_seen) begin
        outstanding--;
      end
      check_true(outstanding <= `GLAY_FIFO_DEPTH, "outstanding reads above the queue depth");

      // In order responses after a random delay
      if (pending.size() > 0 && take_bits(2) != 0) begin
        resp_addr      = pending.pop_front();
        mem_resp_valid = 1'b1;
        mem_resp_data  = mem_data.exists(resp_addr) ? mem_data[resp_addr] : '0;
      end else begin
        mem_resp_valid = 1'b0;
      end

      // Credits come back only for requests already seen
      if (credits_owed > 0 && take_bits(1) == 1) begin
        mem_req_credit = 1'b1;
        credits_owed--;
      end else begin
        mem_req_credit = 1'b0;
      end

      // Long stall stretches on the consumer side
      if (take_bits(5) == 0) begin
        stall = !stall;
      end
      cfg_ready = !stall && (take_bits(2) != 0);

      // Word taken at the coming rising edge
      pop_seen = cfg_valid && cfg_ready;
      if (pop_seen) begin
        exp_addr = cur_base + acc_count * `GLAY_WORD_BYTES;
        check_true(acc_count < cur_count, "config word beyond the word count");
        check_value("cfg_index", cfg_index, acc_count);
        check_value("cfg_data", cfg_data, mem_data.exists(exp_addr) ? mem_data[exp_addr] : '0);
        acc_count++;
      end
    end
  end

  // One full handshake run
  task automatic run_one(input int t);
    int err_start;
    err_start = errors;
    cur_base  = run_base[t];
    cur_count = run_count[t];
    req_count = 0;
    acc_count = 0;
    @(negedge ap_clk);
    check_value("ap_idle", ap_idle, 1);
    desc_base_addr = cur_base;
    desc_num_words = `GLAY_COUNT_BITS'(cur_count);
    ap_start       = 1'b1;
    @(negedge ap_clk);
    ap_start = 1'b0;
    check_value("ap_ready", ap_ready, 1);
    check_value("ap_idle", ap_idle, 0);
    @(negedge ap_clk);
    check_value("ap_ready", ap_ready, 0);
    while (ap_done !== 1'b1) begin
      @(negedge ap_clk);
    end
    check_value("words accepted", acc_count, cur_count);
    check_value("requests issued", req_count, cur_count);
    check_true(pending.size() == 0, "responses still pending at done");
    // Done must hold until acknowledged
    repeat (run_wait[t]) begin
      @(negedge ap_clk);
      check_true(ap_done, "ap_done dropped before ap_continue");
    end
    ap_continue = 1'b1;
    @(negedge ap_clk);
    ap_continue = 1'b0;
    check_value("ap_done", ap_done, 0);
    check_value("ap_idle", ap_idle, 1);
    close_test($sformatf("run %0d base %h count %0d", t, cur_base, cur_count), err_start);
  endtask

  // ------------------------------
  // Sequencer
  // ------------------------------
  initial begin
    int t;
    int i;
    int total;
    int err_start;
    control_areset = 1'b1;
    ap_start       = 1'b0;
    ap_continue    = 1'b0;
    desc_base_addr = '0;
    desc_num_words = '0;
    mem_req_credit = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    cfg_ready      = 1'b0;
    lfsr           = 32'h3489_04f2;
    errors         = 0;
    tests_failed   = 0;
    credits_held   = `GLAY_MEM_CREDITS;
    credits_owed   = 0;
    outstanding    = 0;
    pop_seen       = 1'b0;
    stall          = 1'b0;
    cur_base       = '0;
    cur_count      = 0;
    total          = 0;

    // Descriptors and memory contents fixed up front
    // Run 1 always has zero words
    for (t = 0; t < num_runs; t++) begin
      run_base[t]  = take_bits(30) << 2;
      run_count[t] = (t == 1) ? 0 : int'(take_bits(6) % 41);
      run_wait[t]  = take_bits(3);
      for (i = 0; i < run_count[t]; i++) begin
        exp_addr = run_base[t] + i * `GLAY_WORD_BYTES;
        if (!mem_data.exists(exp_addr)) begin
          mem_data[exp_addr] = take_bits(32);
        end
      end
      total += run_count[t];
    end
    limit_cycles = 32 + total * word_cycles + num_runs * run_cycles;

    repeat (16) @(posedge ap_clk);
    @(negedge ap_clk);
    control_areset = 1'b0;
    @(negedge ap_clk);
    err_start = errors;
    check_value("ap_idle", ap_idle, 1);
    check_value("ap_ready", ap_ready, 0);
    check_value("ap_done", ap_done, 0);
    check_value("mem_req_valid", mem_req_valid, 0);
    check_value("cfg_valid", cfg_valid, 0);
    close_test("reset state", err_start);

    for (t = 0; t < num_runs; t++) begin
      run_one(t);
    end

    $display("tests %0d, failed %0d, errors %0d", num_runs + 1, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the total word count
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge ap_clk);
    $display("Timeout: runs still busy after %0d cycles", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : glay_compute_unit_tb

// File: glay_compute_unit.f
+incdir+rtl
rtl/glay_mem_pkg.sv
rtl/glay_control_pkg.sv
rtl/glay_fifo_if.sv
rtl/glay_sync_fifo.sv
rtl/glay_kernel_control.sv
rtl/glay_kernel_setup.sv
rtl/glay_request_generator.sv
rtl/glay_compute_unit.sv
verification/glay_compute_unit_tb.sv
